/* common/lsu_pkg.sv */
// load/store request constants and address field positions, imported by the adapter RTL
`default_nettype none

package lsu_pkg;

    parameter int PADDR_WIDTH = 32;
    parameter int LANE_WIDTH  = 32;   // one word lane
    parameter int LANES       = 4;
    parameter int BEAT_WIDTH  = LANE_WIDTH * LANES;
    parameter int RDATA_WIDTH = 64;   // two lanes back to the cpu

    // data sram addressing
    parameter int SET_LSB         = 4;
    parameter int SET_MSB         = 11;
    parameter int LANE_LSB        = 2;   // addr[3:2] picks the lane
    parameter int SRAM_ADDR_WIDTH = 12;
    parameter int WAY_WIDTH       = 2;

    // cpu access size, log2 of bytes
    parameter logic [1:0] SIZE_BYTE  = 2'd0;
    parameter logic [1:0] SIZE_HALF  = 2'd1;
    parameter logic [1:0] SIZE_WORD  = 2'd2;
    parameter logic [1:0] SIZE_DWORD = 2'd3;

endpackage

`default_nettype wire

/* common/tl_pkg.sv */
// tilelink opcode codes and channel field widths for the A and D channel ports
`default_nettype none

package tl_pkg;

    parameter int OPCODE_WIDTH = 3;
    parameter int PARAM_WIDTH  = 3;
    parameter int SIZE_WIDTH   = 4;
    parameter int MASK_WIDTH   = 16;   // one bit per byte of the beat

    // channel A
    parameter logic [OPCODE_WIDTH-1:0] PUT_FULL_DATA = 3'd0;
    parameter logic [OPCODE_WIDTH-1:0] GET           = 3'd4;

    // channel D
    parameter logic [OPCODE_WIDTH-1:0] ACCESS_ACK      = 3'd0;
    parameter logic [OPCODE_WIDTH-1:0] ACCESS_ACK_DATA = 3'd1;

endpackage

`default_nettype wire

/* list.f */
common/lsu_pkg.sv
common/tl_pkg.sv
verilog/lsu_req_sequencer.sv
unc/unc_tl_stage.sv
verilog/unc_resp_collect.sv
verilog/wired_unc_adapter.sv
verif/unc_adapter_sva.sv
verif/unc_checker.sv
verif/tb_unc_adapter.sv

/* run.sh */
#!/bin/bash
# build and run the uncached adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_unc_adapter \
    -f list.f -o sim_unc_adapter
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_unc_adapter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1

/* unc/unc_tl_stage.sv */
// one-entry uncached stage: issues a Get or PutFullData on channel A, then takes the matching D ack
`default_nettype none
`timescale 1ns/100ps

module unc_tl_stage #(
    parameter int unsigned                SOURCE_WIDTH = 1,
    parameter logic [SOURCE_WIDTH-1:0]    SOURCE_BASE  = '0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 unc_call_i,
    input  logic                                 unc_wreq_i,
    input  logic [lsu_pkg::PADDR_WIDTH-1:0]      unc_addr_i,
    input  logic [1:0]                           unc_size_i,
    input  logic [3:0]                           unc_strb_i,
    input  logic [3:0]                           unc_histrb_i,
    input  logic [lsu_pkg::LANE_WIDTH-1:0]       unc_wdata_i,
    input  logic                                 tl_a_ready_i,
    input  logic                                 tl_d_valid_i,
    input  logic [tl_pkg::OPCODE_WIDTH-1:0]      tl_d_opcode_i,
    output logic                                 tl_a_valid_o,
    output logic [tl_pkg::OPCODE_WIDTH-1:0]      tl_a_opcode_o,
    output logic [tl_pkg::PARAM_WIDTH-1:0]       tl_a_param_o,
    output logic [tl_pkg::SIZE_WIDTH-1:0]        tl_a_size_o,
    output logic [SOURCE_WIDTH-1:0]              tl_a_source_o,
    output logic [lsu_pkg::PADDR_WIDTH-1:0]      tl_a_address_o,
    output logic [tl_pkg::MASK_WIDTH-1:0]        tl_a_mask_o,
    output logic [lsu_pkg::BEAT_WIDTH-1:0]       tl_a_data_o,
    output logic                                 tl_d_ready_o,
    output logic                                 unc_ret_o,
    output logic                                 unc_ret_wreq_o,
    output logic [1:0]                           unc_ret_lane_o
);
    import lsu_pkg::*;
    import tl_pkg::*;

    localparam int LANE_BYTES = LANE_WIDTH / 8;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_A    = 2'd1;
    localparam logic [1:0] S_WD   = 2'd2;   // waiting AccessAck
    localparam logic [1:0] S_RD   = 2'd3;   // waiting AccessAckData

    logic [1:0]             state_q;
    logic                   wreq_q;
    logic [1:0]             size_q;
    logic [PADDR_WIDTH-1:0] addr_q;
    logic [MASK_WIDTH-1:0]  mask_q;
    logic [BEAT_WIDTH-1:0]  data_q;
    logic [MASK_WIDTH-1:0]  mask_d;
    logic [BEAT_WIDTH-1:0]  data_d;
    logic [1:0]             lo_lane;
    logic [1:0]             hi_lane;
    logic                   capture;

    assign capture = (state_q == S_IDLE) && unc_call_i;
    assign lo_lane = unc_addr_i[LANE_LSB+1:LANE_LSB];
    assign hi_lane = {unc_addr_i[LANE_LSB+1], 1'b1};   // second word of a dword

    always_comb begin
        mask_d = '0;
        data_d = '0;
        mask_d[hi_lane*LANE_BYTES +: LANE_BYTES] = unc_histrb_i;
        mask_d[lo_lane*LANE_BYTES +: LANE_BYTES] = unc_strb_i;
        data_d[lo_lane*LANE_WIDTH +: LANE_WIDTH] = unc_wdata_i;
    end

    // D is taken only when the opcode matches the outstanding request
    assign tl_d_ready_o = tl_d_valid_i
                          && (((state_q == S_WD) && (tl_d_opcode_i == ACCESS_ACK))
                          || ((state_q == S_RD) && (tl_d_opcode_i == ACCESS_ACK_DATA)));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE:  if (unc_call_i) state_q <= S_A;
                S_A:     if (tl_a_ready_i) state_q <= wreq_q ? S_WD : S_RD;
                default: if (tl_d_ready_o) state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            wreq_q <= unc_wreq_i;
            size_q <= unc_size_i;
            addr_q <= unc_addr_i;
            mask_q <= mask_d;
            data_q <= data_d;
        end
    end

    assign tl_a_valid_o   = (state_q == S_A);
    assign tl_a_opcode_o  = wreq_q ? PUT_FULL_DATA : GET;
    assign tl_a_param_o   = '0;
    assign tl_a_size_o    = SIZE_WIDTH'(size_q);
    assign tl_a_source_o  = SOURCE_BASE;
    assign tl_a_address_o = addr_q;
    assign tl_a_mask_o    = mask_q;
    assign tl_a_data_o    = data_q;

    assign unc_ret_o      = tl_d_ready_o;   // pulse on the D transfer
    assign unc_ret_wreq_o = wreq_q;
    assign unc_ret_lane_o = addr_q[LANE_LSB+1:LANE_LSB];

endmodule

`default_nettype wire

/* verif/tb_unc_adapter.sv */
// testbench top for the uncached adapter: clock, reset, request table, TileLink slave, run limit
`default_nettype none
`timescale 1ns/100ps

module tb_unc_adapter;
    import lsu_pkg::*;
    import tl_pkg::*;

    localparam int         N_ENTRIES = 16;
    localparam logic [1:0] K_LOAD    = 2'd0;
    localparam logic [1:0] K_STORE   = 2'd1;
    localparam logic [1:0] K_WB      = 2'd2;

    logic clk, rst_n;
    logic req_valid_i, req_uncached_load_i, req_uncached_store_i;
    logic [31:0] req_paddr_i, req_wdata_i;
    logic [1:0] req_size_i, wb_way_i;
    logic wb_req_i, resp_ready_o, tl_a_valid_o, tl_a_ready_i, tl_d_valid_i, tl_d_ready_o;
    logic [3:0] wb_wstrb_i, tl_a_size_o;
    logic [63:0] resp_rdata_o;
    logic [11:0] m_addr_o;
    logic [15:0] m_wstrb_o, tl_a_mask_o;
    logic [127:0] m_wdata_o, tl_a_data_o, tl_d_data_i;
    logic [1:0] m_way_o;
    logic [2:0] tl_a_opcode_o, tl_a_param_o, tl_d_opcode_i;
    logic tl_a_source_o;
    logic [31:0] tl_a_address_o;

    // table columns
    logic [1:0]  t_kind  [N_ENTRIES];
    logic [31:0] t_paddr [N_ENTRIES];
    logic [1:0]  t_size  [N_ENTRIES];   // also the way for a writeback
    logic [31:0] t_wdata [N_ENTRIES];
    logic [3:0]  t_strb  [N_ENTRIES];
    int          t_stall [N_ENTRIES];
    int          t_delay [N_ENTRIES];
    logic        t_wrong [N_ENTRIES];

    logic [1:0]   cur_kind;
    logic [127:0] cur_d_data;
    logic [31:0]  rng;
    int n_fill, limit, cycles, resp_count, value_errors, other_errors;

    wired_unc_adapter u_wired_unc_adapter (.*);

    unc_checker u_unc_checker (
        .clk, .rst_n, .kind_i(cur_kind), .paddr_i(req_paddr_i), .size_i(req_size_i),
        .wdata_i(req_wdata_i), .way_i(wb_way_i), .strb_i(wb_wstrb_i), .d_data_i(cur_d_data),
        .wb_req_i, .tl_a_ready_i, .tl_d_valid_i, .tl_d_opcode_i, .tl_a_valid_o, .tl_a_opcode_o,
        .tl_a_param_o, .tl_a_size_o, .tl_a_source_o, .tl_a_address_o, .tl_a_mask_o,
        .tl_a_data_o, .tl_d_ready_o, .resp_ready_o, .resp_rdata_o, .m_way_o, .m_addr_o,
        .m_wstrb_o, .m_wdata_o, .value_err_o(value_errors), .other_err_o(other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_entry(input logic [1:0] kind, input logic [31:0] paddr,
                             input logic [1:0] size, input logic [31:0] wdata,
                             input logic [3:0] strb, input int stall, input int delay,
                             input logic wrong);
        t_kind[n_fill]  = kind;
        t_paddr[n_fill] = paddr;
        t_size[n_fill]  = size;
        t_wdata[n_fill] = wdata;
        t_strb[n_fill]  = strb;
        t_stall[n_fill] = stall;
        t_delay[n_fill] = delay;
        t_wrong[n_fill] = wrong;
        n_fill++;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic make_beat(output logic [127:0] beat);
        for (int k = 0; k < 4; k++) begin
            rng = xorshift(rng);
            beat[k*32 +: 32] = rng;
        end
    endtask

    // slave side of one load or store, CPU holds the request until the response
    task automatic run_request(input int i);
        int rc0;
        logic [127:0] beat;
        rc0 = resp_count;
        req_valid_i = 1'b1;
        req_uncached_load_i  = (t_kind[i] == K_LOAD);
        req_uncached_store_i = (t_kind[i] == K_STORE);
        @(negedge clk);
        while (!tl_a_valid_o) @(negedge clk);
        repeat (t_stall[i]) @(negedge clk);
        tl_a_ready_i = 1'b1;
        @(negedge clk);
        tl_a_ready_i = 1'b0;
        repeat (t_delay[i]) @(negedge clk);
        if (t_wrong[i]) begin
            make_beat(beat);
            tl_d_valid_i  = 1'b1;
            tl_d_opcode_i = (t_kind[i] == K_STORE) ? ACCESS_ACK_DATA : ACCESS_ACK;
            tl_d_data_i   = beat;
            @(negedge clk);
        end
        make_beat(beat);
        cur_d_data    = beat;
        tl_d_data_i   = beat;
        tl_d_valid_i  = 1'b1;
        tl_d_opcode_i = (t_kind[i] == K_STORE) ? ACCESS_ACK : ACCESS_ACK_DATA;
        @(negedge clk);
        tl_d_valid_i = 1'b0;
        while (resp_count == rc0) @(negedge clk);
        req_valid_i = 1'b0;
        req_uncached_load_i  = 1'b0;
        req_uncached_store_i = 1'b0;
    endtask

    always @(posedge clk) begin
        if (resp_ready_o)
            resp_count <= resp_count + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        {req_valid_i, req_uncached_load_i, req_uncached_store_i, wb_req_i} = '0;
        {req_paddr_i, req_wdata_i, req_size_i, wb_way_i, wb_wstrb_i} = '0;
        {tl_a_ready_i, tl_d_valid_i, tl_d_opcode_i, tl_d_data_i} = '0;
        cur_kind = K_WB;
        cur_d_data = '0;
        {n_fill, cycles, resp_count} = '0;
        rng = 32'd7;
        //        kind     paddr         size   wdata          strb   st dl wrong
        add_entry(K_LOAD,  32'h80001005, 2'd0, 32'h0,         4'h0,  0, 0, 1'b0);
        add_entry(K_LOAD,  32'h8000100a, 2'd1, 32'h0,         4'h0,  1, 2, 1'b0);
        add_entry(K_LOAD,  32'h80001018, 2'd2, 32'h0,         4'h0,  0, 1, 1'b1);
        add_entry(K_LOAD,  32'h80001020, 2'd3, 32'h0,         4'h0,  2, 0, 1'b0);
        add_entry(K_LOAD,  32'h80001028, 2'd3, 32'h0,         4'h0,  0, 0, 1'b0);
        add_entry(K_STORE, 32'h80002003, 2'd0, 32'h000000a5,  4'h0,  0, 0, 1'b0);
        add_entry(K_STORE, 32'h80002006, 2'd1, 32'h0000beef,  4'h0,  3, 1, 1'b0);
        add_entry(K_STORE, 32'h8000200c, 2'd2, 32'hcafe1234,  4'h0,  0, 2, 1'b1);
        add_entry(K_WB,    32'h00000234, 2'd1, 32'h11223344,  4'hf,  0, 0, 1'b0);
        add_entry(K_WB,    32'h00000ff8, 2'd3, 32'h55667788,  4'h5,  0, 0, 1'b0);
        add_entry(K_LOAD,  32'h80003034, 2'd2, 32'h0,         4'h0,  4, 3, 1'b1);
        add_entry(K_STORE, 32'h80003038, 2'd2, 32'h0badf00d,  4'h0,  1, 0, 1'b0);
        add_entry(K_WB,    32'h12345670, 2'd2, 32'h99aabbcc,  4'hc,  0, 0, 1'b0);
        add_entry(K_LOAD,  32'h80004000, 2'd3, 32'h0,         4'h0,  0, 5, 1'b1);
        add_entry(K_STORE, 32'h80004001, 2'd0, 32'h0000005a,  4'h0,  2, 0, 1'b0);
        add_entry(K_LOAD,  32'h80004012, 2'd1, 32'h0,         4'h0,  0, 0, 1'b0);
        limit = 20;
        for (int i = 0; i < N_ENTRIES; i++)
            limit += t_stall[i] + t_delay[i] + 10;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < N_ENTRIES; i++) begin
            @(negedge clk);
            cur_kind    = t_kind[i];
            req_paddr_i = t_paddr[i];
            req_size_i  = t_size[i];
            req_wdata_i = t_wdata[i];
            if (t_kind[i] == K_WB) begin
                wb_req_i   = 1'b1;
                wb_way_i   = t_size[i];
                wb_wstrb_i = t_strb[i];
                @(negedge clk);
                wb_req_i = 1'b0;
            end else begin
                run_request(i);
            end
        end
        repeat (2) @(negedge clk);
        $display("run done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/unc_adapter_sva.sv */
// concurrent assertions on the adapter's A and D handshakes bound into the top level
`default_nettype none
`timescale 1ns/100ps

module unc_adapter_sva (
    input logic         clk, rst_n,
    input logic         tl_a_valid_o, tl_a_ready_i,
    input logic [2:0]   tl_a_opcode_o,
    input logic [3:0]   tl_a_size_o,
    input logic [31:0]  tl_a_address_o,
    input logic [15:0]  tl_a_mask_o,
    input logic [127:0] tl_a_data_o,
    input logic         tl_d_valid_i, tl_d_ready_o, resp_ready_o,
    input logic [2:0]   tl_d_opcode_i
);
    import tl_pkg::*;

    logic a_get_q;   // last A transfer was a Get

    always @(posedge clk) begin
        if (tl_a_valid_o && tl_a_ready_i)
            a_get_q <= (tl_a_opcode_o == GET);
    end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tl_a_valid_o && !tl_a_ready_i |=> tl_a_valid_o && $stable(tl_a_opcode_o)
            && $stable(tl_a_size_o) && $stable(tl_a_address_o)
            && $stable(tl_a_mask_o) && $stable(tl_a_data_o))
        else $error("channel A dropped or changed while stalled");

    // D is only taken for the ack that answers the A request already sent
    d_ready_match: assert property (@(posedge clk) disable iff (!rst_n)
        tl_d_ready_o |-> tl_d_valid_i && !tl_a_valid_o
            && (tl_d_opcode_i == (a_get_q ? ACCESS_ACK_DATA : ACCESS_ACK)))
        else $error("tl_d_ready_o high without a matching D beat for the sent request");

    resp_single: assert property (@(posedge clk) disable iff (!rst_n)
        resp_ready_o |=> !resp_ready_o)
        else $error("resp_ready_o high on two cycles in a row");
endmodule

bind wired_unc_adapter unc_adapter_sva u_unc_adapter_sva (
    .clk(clk), .rst_n(rst_n), .tl_a_valid_o(tl_a_valid_o), .tl_a_ready_i(tl_a_ready_i),
    .tl_a_opcode_o(tl_a_opcode_o), .tl_a_size_o(tl_a_size_o),
    .tl_a_address_o(tl_a_address_o), .tl_a_mask_o(tl_a_mask_o), .tl_a_data_o(tl_a_data_o),
    .tl_d_valid_i(tl_d_valid_i), .tl_d_ready_o(tl_d_ready_o), .resp_ready_o(resp_ready_o),
    .tl_d_opcode_i(tl_d_opcode_i)
);

`default_nettype wire

/* verif/unc_checker.sv */
// watches the adapter ports each rising clock and compares them with values from the request
`default_nettype none
`timescale 1ns/100ps

module unc_checker (
    input  logic         clk, rst_n,
    input  logic [1:0]   kind_i, size_i, way_i,
    input  logic [31:0]  paddr_i, wdata_i,
    input  logic [3:0]   strb_i,
    input  logic [127:0] d_data_i,
    input  logic         wb_req_i, tl_a_ready_i, tl_d_valid_i,
    input  logic [2:0]   tl_d_opcode_i, tl_a_opcode_o, tl_a_param_o,
    input  logic         tl_a_valid_o, tl_a_source_o, tl_d_ready_o, resp_ready_o,
    input  logic [3:0]   tl_a_size_o,
    input  logic [31:0]  tl_a_address_o,
    input  logic [15:0]  tl_a_mask_o, m_wstrb_o,
    input  logic [127:0] tl_a_data_o, m_wdata_o,
    input  logic [63:0]  resp_rdata_o,
    input  logic [1:0]   m_way_o,
    input  logic [11:0]  m_addr_o,
    output int           value_err_o,
    output int           other_err_o
);
    import tl_pkg::*;

    logic first_q, ld_ret_q;
    logic is_load, is_store, exp_dready, exp_resp;
    logic [1:0] lane;
    int a_xfers;

    task automatic value_mismatch(input string sig, input logic [127:0] exp,
                                  input logic [127:0] act);
        $display("FAIL %0t %s expected %h got %h", $time, sig, exp, act);
        value_err_o++;
    endtask

    task automatic check(input string sig, input logic [127:0] exp, input logic [127:0] act);
        if (act !== exp)
            value_mismatch(sig, exp, act);
    endtask

    // byte enables for the whole beat
    function automatic logic [15:0] beat_mask(input logic [31:0] a, input logic [1:0] sz);
        logic [3:0] lo;
        logic [3:0] hi;
        case (sz)
            2'd0:    lo = 4'b0001 << a[1:0];
            2'd1:    lo = a[1] ? 4'b1100 : 4'b0011;
            default: lo = 4'b1111;
        endcase
        hi = (sz == 2'd3) ? 4'b1111 : 4'b0000;
        return (16'(hi) << ({a[3], 1'b1} * 4)) | (16'(lo) << (a[3:2] * 4));
    endfunction

    initial begin
        value_err_o = 0;
        other_err_o = 0;
        a_xfers = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            first_q  <= 1'b1;
            ld_ret_q <= 1'b0;
            a_xfers = 0;
        end else begin
            if (first_q) begin   // idle outputs right out of reset
                check("tl_a_valid_o", 0, tl_a_valid_o);
                first_q <= 1'b0;
            end
            is_load    = (kind_i == 2'd0);
            is_store   = (kind_i == 2'd1);
            lane       = paddr_i[3:2];
            exp_dready = tl_d_valid_i && (is_load || is_store)
                         && (tl_d_opcode_i == (is_store ? ACCESS_ACK : ACCESS_ACK_DATA));
            exp_resp   = (exp_dready && is_store) || ld_ret_q;
            if (tl_a_valid_o) begin
                check("tl_a_opcode_o", is_store ? PUT_FULL_DATA : GET, tl_a_opcode_o);
                check("tl_a_param_o", 0, tl_a_param_o);
                check("tl_a_size_o", size_i, tl_a_size_o);
                check("tl_a_source_o", 0, tl_a_source_o);
                check("tl_a_address_o", paddr_i, tl_a_address_o);
                check("tl_a_mask_o", beat_mask(paddr_i, size_i), tl_a_mask_o);
                if (is_store)
                    check("tl_a_data_o", 128'(wdata_i) << (lane * 32), tl_a_data_o);
                if (tl_a_ready_i)
                    a_xfers++;
            end
            check("tl_d_ready_o", exp_dready, tl_d_ready_o);
            check("resp_ready_o", exp_resp, resp_ready_o);
            if (exp_resp) begin
                if (a_xfers != 1) begin
                    $display("error at %0t: %0d channel A transfers for one request",
                             $time, a_xfers);
                    other_err_o++;
                end
                a_xfers = 0;
                if (ld_ret_q)
                    check("resp_rdata_o", {d_data_i[{lane[1], 1'b1}*32 +: 32],
                                           d_data_i[lane*32 +: 32]}, resp_rdata_o);
            end
            check("m_wstrb_o", wb_req_i ? (16'(strb_i) << (lane * 4)) : 16'h0, m_wstrb_o);
            if (wb_req_i) begin
                check("m_addr_o", {paddr_i[11:4], 4'h0}, m_addr_o);
                check("m_way_o", way_i, m_way_o);
                check("m_wdata_o", 128'(wdata_i) << (lane * 32), m_wdata_o);
            end
            ld_ret_q <= exp_dready && is_load;
        end
    end

endmodule

`default_nettype wire

/* verilog/lsu_req_sequencer.sv */
// takes cpu uncached requests into the uncached stage and drives the data sram writeback port
`default_nettype none
`timescale 1ns/100ps

module lsu_req_sequencer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_valid_i,
    input  logic                                 req_uncached_load_i,
    input  logic                                 req_uncached_store_i,
    input  logic [lsu_pkg::PADDR_WIDTH-1:0]      req_paddr_i,
    input  logic [1:0]                           req_size_i,
    input  logic [lsu_pkg::LANE_WIDTH-1:0]       req_wdata_i,
    input  logic                                 wb_req_i,
    input  logic [lsu_pkg::WAY_WIDTH-1:0]        wb_way_i,
    input  logic [3:0]                           wb_wstrb_i,
    input  logic                                 unc_ret_i,
    input  logic                                 resp_ready_i,
    output logic                                 unc_call_o,
    output logic                                 unc_wreq_o,
    output logic [lsu_pkg::PADDR_WIDTH-1:0]      unc_addr_o,
    output logic [1:0]                           unc_size_o,
    output logic [3:0]                           unc_strb_o,
    output logic [3:0]                           unc_histrb_o,
    output logic [lsu_pkg::LANE_WIDTH-1:0]       unc_wdata_o,
    output logic [lsu_pkg::WAY_WIDTH-1:0]        m_way_o,
    output logic [lsu_pkg::SRAM_ADDR_WIDTH-1:0]  m_addr_o,
    output logic [lsu_pkg::BEAT_WIDTH/8-1:0]     m_wstrb_o,
    output logic [lsu_pkg::BEAT_WIDTH-1:0]       m_wdata_o
);
    import lsu_pkg::*;

    localparam int LANE_BYTES = LANE_WIDTH / 8;

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_LOAD  = 2'd1;   // calling stage with a Get
    localparam logic [1:0] S_STORE = 2'd2;   // calling stage with a PutFullData
    localparam logic [1:0] S_WAIT  = 2'd3;   // stage done, response still pending

    logic [1:0]             state_q;
    logic [PADDR_WIDTH-1:0] addr_q;
    logic [1:0]             size_q;
    logic [LANE_WIDTH-1:0]  wdata_q;
    logic                   accept;
    logic [1:0]             wb_lane;

    assign accept = (state_q == S_IDLE) && req_valid_i
                    && (req_uncached_load_i || req_uncached_store_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept)
                        state_q <= req_uncached_store_i ? S_STORE : S_LOAD;
                end
                S_LOAD, S_STORE: begin
                    if (unc_ret_i)
                        state_q <= resp_ready_i ? S_IDLE : S_WAIT;
                end
                default: begin
                    if (resp_ready_i)
                        state_q <= S_IDLE;
                end
            endcase
        end
    end

    // request payload, held for the whole call
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= req_paddr_i;
            size_q  <= req_size_i;
            wdata_q <= req_wdata_i;
        end
    end

    assign unc_call_o  = (state_q == S_LOAD) || (state_q == S_STORE);
    assign unc_wreq_o  = (state_q == S_STORE);
    assign unc_addr_o  = addr_q;
    assign unc_size_o  = size_q;
    assign unc_wdata_o = wdata_q;

    // byte strobes inside the addressed lane
    always_comb begin
        case (size_q)
            SIZE_BYTE: unc_strb_o = 4'b0001 << addr_q[1:0];
            SIZE_HALF: unc_strb_o = addr_q[1] ? 4'b1100 : 4'b0011;
            default:   unc_strb_o = 4'b1111;   // word, and low half of a dword
        endcase
    end

    assign unc_histrb_o = (size_q == SIZE_DWORD) ? 4'b1111 : 4'b0000;

    // writeback goes straight to the sram, never stalled
    assign wb_lane  = req_paddr_i[LANE_LSB+1:LANE_LSB];
    assign m_way_o  = wb_way_i;
    assign m_addr_o = {req_paddr_i[SET_MSB:SET_LSB], {SET_LSB{1'b0}}};

    always_comb begin
        m_wstrb_o = '0;
        m_wdata_o = '0;
        if (wb_req_i) begin
            m_wstrb_o[wb_lane*LANE_BYTES +: LANE_BYTES] = wb_wstrb_i;
            m_wdata_o[wb_lane*LANE_WIDTH +: LANE_WIDTH] = req_wdata_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/unc_resp_collect.sv */
// picks the load result out of the D beat and forms the cpu response strobe
`default_nettype none
`timescale 1ns/100ps

module unc_resp_collect (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             unc_ret_i,
    input  logic                             unc_ret_wreq_i,
    input  logic [1:0]                       unc_ret_lane_i,
    input  logic [lsu_pkg::BEAT_WIDTH-1:0]   tl_d_data_i,
    output logic                             resp_ready_o,
    output logic [lsu_pkg::RDATA_WIDTH-1:0]  resp_rdata_o
);
    import lsu_pkg::*;

    logic                   pend_q;   // load data captured, answer next cycle
    logic [RDATA_WIDTH-1:0] rdata_q;
    logic                   rd_ret;
    logic [1:0]             hi_lane;

    assign rd_ret  = unc_ret_i && !unc_ret_wreq_i;
    assign hi_lane = {unc_ret_lane_i[1], 1'b1};

    always_ff @(posedge clk) begin
        if (!rst_n)
            pend_q <= 1'b0;
        else
            pend_q <= rd_ret;
    end

    always_ff @(posedge clk) begin
        if (rd_ret) begin
            rdata_q <= {tl_d_data_i[hi_lane*LANE_WIDTH +: LANE_WIDTH],
                        tl_d_data_i[unc_ret_lane_i*LANE_WIDTH +: LANE_WIDTH]};
        end
    end

    // stores answer in the ack cycle itself
    assign resp_ready_o = (unc_ret_i && unc_ret_wreq_i) || pend_q;
    assign resp_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* verilog/wired_unc_adapter.sv */
// uncached dcache bus adapter top, connecting cpu, data sram write port and TileLink A/D
`default_nettype none
`timescale 1ns/100ps

module wired_unc_adapter #(
    parameter int unsigned                SOURCE_WIDTH = 1,
    parameter logic [SOURCE_WIDTH-1:0]    SOURCE_BASE  = '0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // cpu
    input  logic                                 req_valid_i,
    input  logic                                 req_uncached_load_i,
    input  logic                                 req_uncached_store_i,
    input  logic [lsu_pkg::PADDR_WIDTH-1:0]      req_paddr_i,
    input  logic [1:0]                           req_size_i,
    input  logic [lsu_pkg::LANE_WIDTH-1:0]       req_wdata_i,
    output logic                                 resp_ready_o,
    output logic [lsu_pkg::RDATA_WIDTH-1:0]      resp_rdata_o,
    // writeback
    input  logic                                 wb_req_i,
    input  logic [lsu_pkg::WAY_WIDTH-1:0]        wb_way_i,
    input  logic [3:0]                           wb_wstrb_i,
    // data sram write port
    output logic [lsu_pkg::WAY_WIDTH-1:0]        m_way_o,
    output logic [lsu_pkg::SRAM_ADDR_WIDTH-1:0]  m_addr_o,
    output logic [tl_pkg::MASK_WIDTH-1:0]        m_wstrb_o,
    output logic [lsu_pkg::BEAT_WIDTH-1:0]       m_wdata_o,
    // tilelink A
    output logic                                 tl_a_valid_o,
    input  logic                                 tl_a_ready_i,
    output logic [tl_pkg::OPCODE_WIDTH-1:0]      tl_a_opcode_o,
    output logic [tl_pkg::PARAM_WIDTH-1:0]       tl_a_param_o,
    output logic [tl_pkg::SIZE_WIDTH-1:0]        tl_a_size_o,
    output logic [SOURCE_WIDTH-1:0]              tl_a_source_o,
    output logic [lsu_pkg::PADDR_WIDTH-1:0]      tl_a_address_o,
    output logic [tl_pkg::MASK_WIDTH-1:0]        tl_a_mask_o,
    output logic [lsu_pkg::BEAT_WIDTH-1:0]       tl_a_data_o,
    // tilelink D
    input  logic                                 tl_d_valid_i,
    output logic                                 tl_d_ready_o,
    input  logic [tl_pkg::OPCODE_WIDTH-1:0]      tl_d_opcode_i,
    input  logic [lsu_pkg::BEAT_WIDTH-1:0]       tl_d_data_i
);
    import lsu_pkg::*;

    // sequencer to stage call
    logic                   unc_call;
    logic                   unc_wreq;
    logic [PADDR_WIDTH-1:0] unc_addr;
    logic [1:0]             unc_size;
    logic [3:0]             unc_strb;
    logic [3:0]             unc_histrb;
    logic [LANE_WIDTH-1:0]  unc_wdata;
    // stage return
    logic                   unc_ret;
    logic                   unc_ret_wreq;
    logic [1:0]             unc_ret_lane;

    lsu_req_sequencer u_lsu_req_sequencer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .req_valid_i          (req_valid_i),
        .req_uncached_load_i  (req_uncached_load_i),
        .req_uncached_store_i (req_uncached_store_i),
        .req_paddr_i          (req_paddr_i),
        .req_size_i           (req_size_i),
        .req_wdata_i          (req_wdata_i),
        .wb_req_i             (wb_req_i),
        .wb_way_i             (wb_way_i),
        .wb_wstrb_i           (wb_wstrb_i),
        .unc_ret_i            (unc_ret),
        .resp_ready_i         (resp_ready_o),
        .unc_call_o           (unc_call),
        .unc_wreq_o           (unc_wreq),
        .unc_addr_o           (unc_addr),
        .unc_size_o           (unc_size),
        .unc_strb_o           (unc_strb),
        .unc_histrb_o         (unc_histrb),
        .unc_wdata_o          (unc_wdata),
        .m_way_o              (m_way_o),
        .m_addr_o             (m_addr_o),
        .m_wstrb_o            (m_wstrb_o),
        .m_wdata_o            (m_wdata_o)
    );

    unc_tl_stage #(
        .SOURCE_WIDTH (SOURCE_WIDTH),
        .SOURCE_BASE  (SOURCE_BASE)
    ) u_unc_tl_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .unc_call_i     (unc_call),
        .unc_wreq_i     (unc_wreq),
        .unc_addr_i     (unc_addr),
        .unc_size_i     (unc_size),
        .unc_strb_i     (unc_strb),
        .unc_histrb_i   (unc_histrb),
        .unc_wdata_i    (unc_wdata),
        .tl_a_ready_i   (tl_a_ready_i),
        .tl_d_valid_i   (tl_d_valid_i),
        .tl_d_opcode_i  (tl_d_opcode_i),
        .tl_a_valid_o   (tl_a_valid_o),
        .tl_a_opcode_o  (tl_a_opcode_o),
        .tl_a_param_o   (tl_a_param_o),
        .tl_a_size_o    (tl_a_size_o),
        .tl_a_source_o  (tl_a_source_o),
        .tl_a_address_o (tl_a_address_o),
        .tl_a_mask_o    (tl_a_mask_o),
        .tl_a_data_o    (tl_a_data_o),
        .tl_d_ready_o   (tl_d_ready_o),
        .unc_ret_o      (unc_ret),
        .unc_ret_wreq_o (unc_ret_wreq),
        .unc_ret_lane_o (unc_ret_lane)
    );

    unc_resp_collect u_unc_resp_collect (
        .clk            (clk),
        .rst_n          (rst_n),
        .unc_ret_i      (unc_ret),
        .unc_ret_wreq_i (unc_ret_wreq),
        .unc_ret_lane_i (unc_ret_lane),
        .tl_d_data_i    (tl_d_data_i),
        .resp_ready_o   (resp_ready_o),
        .resp_rdata_o   (resp_rdata_o)
    );

endmodule

`default_nettype wire
